/* logic/isaPkg.sv */
package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [5:0] opcode_t;
    typedef logic [1:0] aluOp_t;

    // Opcode zero is left free so an all-zero word decodes as a bubble
    localparam opcode_t opAdd = 6'h01;
    localparam opcode_t opSub = 6'h02;
    localparam opcode_t opAnd = 6'h03;
    localparam opcode_t opOr = 6'h04;
    localparam opcode_t opAddi = 6'h05;
    localparam opcode_t opLw = 6'h06;
    localparam opcode_t opSw = 6'h07;
    localparam opcode_t opBeqz = 6'h08;
    localparam opcode_t opJal = 6'h09;
    localparam opcode_t opHalt = 6'h3f;

    // Integer ALU operations
    localparam aluOp_t aluAdd = 2'd0;
    localparam aluOp_t aluSub = 2'd1;
    localparam aluOp_t aluAnd = 2'd2;
    localparam aluOp_t aluOr = 2'd3;

    // Register shown on the a0 output
    localparam regIdx_t a0Index = 5'd10;

endpackage

/* logic/pipePkg.sv */
package pipePkg;

    // Operand source for the execute stage
    typedef logic [1:0] fwdSel_t;

    localparam fwdSel_t fwdReg = 2'd0;
    localparam fwdSel_t fwdMem = 2'd1;
    localparam fwdSel_t fwdWb = 2'd2;

    // Value written back to the register file
    typedef logic [1:0] wbSel_t;

    localparam wbSel_t wbAlu = 2'd0;
    localparam wbSel_t wbLoad = 2'd1;
    localparam wbSel_t wbPc4 = 2'd2;

    // Halt machine
    typedef enum logic [1:0] {
        stateRun,
        stateDrain,
        stateHalted
    } ctrlState_t;

endpackage

/* logic/decodeBus.sv */
`timescale 1ns/1ps

interface decodeBus;

    // Control fields
    isaPkg::aluOp_t aluOp;
    logic useImm;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic isBranch;
    logic isJump;
    pipePkg::wbSel_t wbSel;

    // Operands
    isaPkg::word_t rs1Val;
    isaPkg::word_t rs2Val;
    isaPkg::word_t imm;
    isaPkg::word_t pc;
    isaPkg::word_t pcPlus4;

    // Register indices
    isaPkg::regIdx_t rs1;
    isaPkg::regIdx_t rs2;
    isaPkg::regIdx_t rd;

    modport ctrl (
        output aluOp, useImm, regWrite, memRead, memWrite, isBranch, isJump, wbSel,
        output rs1Val, rs2Val, imm, pc, pcPlus4, rs1, rs2, rd
    );

    modport exec (
        input aluOp, useImm, regWrite, memRead, memWrite, isBranch, isJump, wbSel,
        input rs1Val, rs2Val, imm, pc, pcPlus4, rs1, rs2, rd
    );

endinterface

/* logic/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit #(
    parameter int imemWords = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic progWrite,
    input  isaPkg::word_t progAddr,
    input  isaPkg::word_t progData,
    input  logic stall,
    input  logic flush,
    input  logic hold,
    input  logic redirect,
    input  isaPkg::word_t redirectPc,
    output isaPkg::word_t instr,
    output isaPkg::word_t instrPc
);
    localparam int idxBits = $clog2(imemWords);

    isaPkg::word_t imem [imemWords];
    isaPkg::word_t pc;
    isaPkg::word_t fetched;
    logic freeze;

    assign freeze = stall || hold;
    assign fetched = imem[pc[idxBits+1:2]];

    // Program load port, kept alive during reset
    always_ff @(posedge clk) begin
        if (progWrite)
            imem[progAddr[idxBits-1:0]] <= progData;
    end

    always_ff @(posedge clk) begin
        if (!rst)
            pc <= '0;
        else if (redirect)
            pc <= redirectPc;
        else if (!freeze)
            pc <= pc + 32'd4;
    end

    // Fetch to decode register, zero word is a bubble
    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            instr <= '0;
            instrPc <= '0;
        end else if (!freeze) begin
            instr <= fetched;
            instrPc <= pc;
        end
    end

    loadInRange: assert property (@(posedge clk)
        progWrite |-> (progAddr < isaPkg::word_t'(imemWords)));

endmodule

/* logic/pipelineControl.sv */
`timescale 1ns/1ps

module pipelineControl (
    input  logic clk,
    input  logic rst,
    input  isaPkg::word_t instr,
    input  isaPkg::word_t instrPc,
    output isaPkg::regIdx_t rs1Idx,
    output isaPkg::regIdx_t rs2Idx,
    input  isaPkg::word_t rs1Val,
    input  isaPkg::word_t rs2Val,
    input  isaPkg::regIdx_t exRd,
    input  logic exMemRead,
    input  isaPkg::regIdx_t memRd,
    input  logic memRegWrite,
    input  isaPkg::regIdx_t wbRd,
    input  logic wbRegWrite,
    input  logic redirect,
    output logic stall,
    output logic flush,
    output logic hold,
    output pipePkg::fwdSel_t fwdA,
    output pipePkg::fwdSel_t fwdB,
    output logic halted,
    decodeBus.ctrl bus
);
    isaPkg::aluOp_t dAluOp;
    isaPkg::word_t dImm;
    pipePkg::wbSel_t dWbSel;
    pipePkg::ctrlState_t state;
    logic [1:0] drainCnt;
    logic dUseImm;
    logic dRegWrite;
    logic dMemRead;
    logic dMemWrite;
    logic dIsBranch;
    logic dIsJump;
    logic usesRs1;
    logic usesRs2;
    logic isHalt;
    logic haltNow;
    logic issue;

    assign rs1Idx = instr[9:5];
    assign rs2Idx = instr[18:14];

    always_comb begin
        dAluOp = isaPkg::aluAdd;
        dImm = {{16{instr[25]}}, instr[25:10]};
        dWbSel = pipePkg::wbAlu;
        {dUseImm, dRegWrite, dMemRead, dMemWrite, dIsBranch, dIsJump} = '0;
        {usesRs1, usesRs2, isHalt} = '0;
        case (instr[31:26])
            isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr: begin
                dAluOp = instr[27:26] - 2'd1;
                {dRegWrite, usesRs1, usesRs2} = 3'b111;
            end
            isaPkg::opAddi: {dUseImm, dRegWrite, usesRs1} = 3'b111;
            // Loads and stores use rs1 as the address with no offset
            isaPkg::opLw: begin
                dImm = '0;
                dWbSel = pipePkg::wbLoad;
                {dUseImm, dRegWrite, dMemRead, usesRs1} = 4'b1111;
            end
            isaPkg::opSw: begin
                dImm = '0;
                {dUseImm, dMemWrite, usesRs1, usesRs2} = 4'b1111;
            end
            isaPkg::opBeqz: {dIsBranch, usesRs1} = 2'b11;
            isaPkg::opJal: begin
                dWbSel = pipePkg::wbPc4;
                {dIsJump, dRegWrite} = 2'b11;
            end
            isaPkg::opHalt: isHalt = 1'b1;
            default: ;
        endcase
    end

    // Load in execute feeding the instruction in decode
    assign stall = exMemRead && (exRd != '0)
        && ((usesRs1 && exRd == rs1Idx) || (usesRs2 && exRd == rs2Idx));
    assign flush = redirect;
    assign haltNow = (state == pipePkg::stateRun) && isHalt && !redirect;
    assign hold = (state != pipePkg::stateRun) || haltNow;
    assign issue = !flush && !stall && !hold;
    assign halted = (state == pipePkg::stateHalted);

    // Memory stage wins over writeback and r0 is never forwarded
    always_comb begin
        fwdA = pipePkg::fwdReg;
        fwdB = pipePkg::fwdReg;
        if (memRegWrite && memRd != '0 && memRd == bus.rs1)
            fwdA = pipePkg::fwdMem;
        else if (wbRegWrite && wbRd != '0 && wbRd == bus.rs1)
            fwdA = pipePkg::fwdWb;
        if (memRegWrite && memRd != '0 && memRd == bus.rs2)
            fwdB = pipePkg::fwdMem;
        else if (wbRegWrite && wbRd != '0 && wbRd == bus.rs2)
            fwdB = pipePkg::fwdWb;
    end

    // Three drain cycles let older instructions reach writeback
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= pipePkg::stateRun;
            drainCnt <= '0;
        end else if (haltNow) begin
            state <= pipePkg::stateDrain;
            drainCnt <= 2'd2;
        end else if (state == pipePkg::stateDrain) begin
            if (drainCnt == '0)
                state <= pipePkg::stateHalted;
            drainCnt <= drainCnt - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || !issue) begin
            {bus.regWrite, bus.memRead, bus.memWrite, bus.isBranch, bus.isJump} <= '0;
            bus.useImm <= 1'b0;
            bus.aluOp <= isaPkg::aluAdd;
            bus.wbSel <= pipePkg::wbAlu;
        end else begin
            {bus.regWrite, bus.memRead, bus.memWrite} <= {dRegWrite, dMemRead, dMemWrite};
            {bus.isBranch, bus.isJump} <= {dIsBranch, dIsJump};
            bus.useImm <= dUseImm;
            bus.aluOp <= dAluOp;
            bus.wbSel <= dWbSel;
        end
        bus.rs1Val <= rs1Val;
        bus.rs2Val <= rs2Val;
        bus.imm <= dImm;
        bus.pc <= instrPc;
        bus.pcPlus4 <= instrPc + 32'd4;
        bus.rs1 <= rs1Idx;
        bus.rs2 <= rs2Idx;
        bus.rd <= instr[4:0];
    end

    // Stalled instruction waits exactly one cycle in decode
    stallHoldsDecode: assert property (@(posedge clk) disable iff (!rst)
        stall |=> (!stall && $stable(instr)));

    // Younger instruction in fetch never reaches decode after a flush
    flushKillsDecode: assert property (@(posedge clk) disable iff (!rst)
        flush |=> (instr == '0));

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic rst,
    input  isaPkg::regIdx_t rs1Idx,
    input  isaPkg::regIdx_t rs2Idx,
    output isaPkg::word_t rs1Val,
    output isaPkg::word_t rs2Val,
    input  isaPkg::regIdx_t wbRd,
    input  logic wbRegWrite,
    input  isaPkg::word_t wbValue,
    output isaPkg::word_t a0
);
    isaPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wbRegWrite && wbRd != '0) begin
            regs[wbRd] <= wbValue;
        end
    end

    // Reads see a write landing in the same cycle
    assign rs1Val = (wbRegWrite && wbRd != '0 && wbRd == rs1Idx)
        ? wbValue : regs[rs1Idx];
    assign rs2Val = (wbRegWrite && wbRd != '0 && wbRd == rs2Idx)
        ? wbValue : regs[rs2Idx];
    assign a0 = regs[isaPkg::a0Index];

    // Both read ports return zero for r0
    zeroRegReadsZero: assert property (@(posedge clk) disable iff (!rst)
        !((rs1Idx == '0 && rs1Val != '0) || (rs2Idx == '0 && rs2Val != '0)));

endmodule

/* logic/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
    input  logic clk,
    input  logic rst,
    decodeBus.exec bus,
    input  pipePkg::fwdSel_t fwdA,
    input  pipePkg::fwdSel_t fwdB,
    input  isaPkg::word_t memResult,
    input  isaPkg::word_t wbValue,
    output isaPkg::regIdx_t exRd,
    output logic exMemRead,
    output logic redirect,
    output isaPkg::word_t redirectPc,
    output isaPkg::word_t memAlu,
    output isaPkg::word_t memStore,
    output isaPkg::regIdx_t memRdOut,
    output logic memCtrlRegWrite,
    output logic memCtrlRead,
    output logic memCtrlWrite,
    output pipePkg::wbSel_t memCtrlWbSel,
    output isaPkg::word_t memPcPlus4
);
    isaPkg::word_t srcA;
    isaPkg::word_t fwdValB;
    isaPkg::word_t srcB;
    isaPkg::word_t aluResult;

    assign exRd = bus.rd;
    assign exMemRead = bus.memRead;

    always_comb begin
        case (fwdA)
            pipePkg::fwdMem: srcA = memResult;
            pipePkg::fwdWb: srcA = wbValue;
            default: srcA = bus.rs1Val;
        endcase
        case (fwdB)
            pipePkg::fwdMem: fwdValB = memResult;
            pipePkg::fwdWb: fwdValB = wbValue;
            default: fwdValB = bus.rs2Val;
        endcase
    end

    assign srcB = bus.useImm ? bus.imm : fwdValB;

    always_comb begin
        case (bus.aluOp)
            isaPkg::aluSub: aluResult = srcA - srcB;
            isaPkg::aluAnd: aluResult = srcA & srcB;
            isaPkg::aluOr: aluResult = srcA | srcB;
            default: aluResult = srcA + srcB;
        endcase
    end

    // Taken BEQZ or JAL, target is a word offset from pc
    assign redirect = (bus.isBranch && srcA == '0) || bus.isJump;
    assign redirectPc = bus.pc + (bus.imm << 2);

    always_ff @(posedge clk) begin
        if (!rst) begin
            memCtrlRegWrite <= 1'b0;
            memCtrlRead <= 1'b0;
            memCtrlWrite <= 1'b0;
            memCtrlWbSel <= pipePkg::wbAlu;
        end else begin
            memCtrlRegWrite <= bus.regWrite;
            memCtrlRead <= bus.memRead;
            memCtrlWrite <= bus.memWrite;
            memCtrlWbSel <= bus.wbSel;
        end
        memAlu <= aluResult;
        memStore <= fwdValB;
        memRdOut <= bus.rd;
        memPcPlus4 <= bus.pcPlus4;
    end

endmodule

/* logic/memoryUnit.sv */
`timescale 1ns/1ps

module memoryUnit #(
    parameter int dmemWords = 64
) (
    input  logic clk,
    input  logic rst,
    input  isaPkg::word_t memAlu,
    input  isaPkg::word_t memStore,
    input  isaPkg::regIdx_t memRdOut,
    input  logic memCtrlRegWrite,
    input  logic memCtrlRead,
    input  logic memCtrlWrite,
    input  pipePkg::wbSel_t memCtrlWbSel,
    input  isaPkg::word_t memPcPlus4,
    output isaPkg::word_t memResult,
    output isaPkg::regIdx_t memRd,
    output logic memRegWrite,
    output isaPkg::regIdx_t wbRd,
    output logic wbRegWrite,
    output isaPkg::word_t wbValue
);
    localparam int idxBits = $clog2(dmemWords);

    isaPkg::word_t dmem [dmemWords];
    isaPkg::word_t loadData;
    isaPkg::word_t wbAlu;
    isaPkg::word_t wbLoad;
    isaPkg::word_t wbPc4;
    pipePkg::wbSel_t wbSel;

    // Word addressed, the ALU result is the word index
    assign loadData = dmem[memAlu[idxBits-1:0]];
    assign memResult = memAlu;
    assign memRd = memRdOut;
    assign memRegWrite = memCtrlRegWrite;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < dmemWords; i++)
                dmem[i] <= '0;
        end else if (memCtrlWrite) begin
            dmem[memAlu[idxBits-1:0]] <= memStore;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wbRegWrite <= 1'b0;
            wbSel <= pipePkg::wbAlu;
        end else begin
            wbRegWrite <= memCtrlRegWrite;
            wbSel <= memCtrlWbSel;
        end
        wbRd <= memRdOut;
        wbAlu <= memAlu;
        wbLoad <= loadData;
        wbPc4 <= memPcPlus4;
    end

    always_comb begin
        case (wbSel)
            pipePkg::wbLoad: wbValue = wbLoad;
            pipePkg::wbPc4: wbValue = wbPc4;
            default: wbValue = wbAlu;
        endcase
    end

    accessInRange: assert property (@(posedge clk) disable iff (!rst)
        (memCtrlRead || memCtrlWrite) |-> (memAlu < isaPkg::word_t'(dmemWords)));

endmodule

/* logic/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic progWrite,
    input  isaPkg::word_t progAddr,
    input  isaPkg::word_t progData,
    output isaPkg::word_t a0,
    output logic halted
);
    isaPkg::word_t instr;
    isaPkg::word_t instrPc;
    isaPkg::regIdx_t rs1Idx;
    isaPkg::regIdx_t rs2Idx;
    isaPkg::word_t rs1Val;
    isaPkg::word_t rs2Val;
    isaPkg::regIdx_t exRd;
    logic exMemRead;
    isaPkg::regIdx_t memRd;
    logic memRegWrite;
    isaPkg::word_t memResult;
    isaPkg::regIdx_t wbRd;
    logic wbRegWrite;
    isaPkg::word_t wbValue;
    logic redirect;
    isaPkg::word_t redirectPc;
    logic stall;
    logic flush;
    logic hold;
    pipePkg::fwdSel_t fwdA;
    pipePkg::fwdSel_t fwdB;
    isaPkg::word_t memAlu;
    isaPkg::word_t memStore;
    isaPkg::regIdx_t memRdOut;
    logic memCtrlRegWrite;
    logic memCtrlRead;
    logic memCtrlWrite;
    pipePkg::wbSel_t memCtrlWbSel;
    isaPkg::word_t memPcPlus4;

    // Decoded entry from control into execute
    decodeBus bus ();

    fetchUnit #(.imemWords(imemWords)) uFetch (
        .clk(clk), .rst(rst), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .stall(stall), .flush(flush), .hold(hold),
        .redirect(redirect), .redirectPc(redirectPc), .instr(instr), .instrPc(instrPc)
    );

    pipelineControl uControl (
        .clk(clk), .rst(rst), .instr(instr), .instrPc(instrPc),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rs1Val(rs1Val), .rs2Val(rs2Val),
        .exRd(exRd), .exMemRead(exMemRead), .memRd(memRd), .memRegWrite(memRegWrite),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite), .redirect(redirect), .stall(stall),
        .flush(flush), .hold(hold), .fwdA(fwdA), .fwdB(fwdB), .halted(halted),
        .bus(bus.ctrl)
    );

    regFile uRegs (
        .clk(clk), .rst(rst), .rs1Idx(rs1Idx), .rs2Idx(rs2Idx),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .wbRd(wbRd), .wbRegWrite(wbRegWrite),
        .wbValue(wbValue), .a0(a0)
    );

    executeUnit uExec (
        .clk(clk), .rst(rst), .bus(bus.exec), .fwdA(fwdA), .fwdB(fwdB),
        .memResult(memResult), .wbValue(wbValue), .exRd(exRd), .exMemRead(exMemRead),
        .redirect(redirect), .redirectPc(redirectPc), .memAlu(memAlu),
        .memStore(memStore), .memRdOut(memRdOut), .memCtrlRegWrite(memCtrlRegWrite),
        .memCtrlRead(memCtrlRead), .memCtrlWrite(memCtrlWrite),
        .memCtrlWbSel(memCtrlWbSel), .memPcPlus4(memPcPlus4)
    );

    memoryUnit #(.dmemWords(dmemWords)) uMem (
        .clk(clk), .rst(rst), .memAlu(memAlu), .memStore(memStore),
        .memRdOut(memRdOut), .memCtrlRegWrite(memCtrlRegWrite),
        .memCtrlRead(memCtrlRead), .memCtrlWrite(memCtrlWrite),
        .memCtrlWbSel(memCtrlWbSel), .memPcPlus4(memPcPlus4), .memResult(memResult),
        .memRd(memRd), .memRegWrite(memRegWrite), .wbRd(wbRd),
        .wbRegWrite(wbRegWrite), .wbValue(wbValue)
    );

endmodule

/* verification/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    // Seven program runs in total since the reset test runs three times
    localparam int unsigned runCount = 7;
    localparam int unsigned cyclesPerRun = 200;
    localparam int unsigned cycleLimit = runCount * cyclesPerRun;

    logic clk;
    logic rst;
    logic progWrite;
    isaPkg::word_t progAddr;
    isaPkg::word_t progData;
    isaPkg::word_t a0;
    logic halted;
    isaPkg::word_t progWords [$];
    logic [31:0] rngState;
    int unsigned cycleCount = 0;

    cpuTop #(.imemWords(64), .dmemWords(64)) u_dut (
        .clk(clk), .rst(rst), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .a0(a0), .halted(halted)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Cycle limit reached before the tests finished");
        end
    end

    // Register format with rs2 at 18..14, rs1 at 9..5 and rd at 4..0
    function automatic isaPkg::word_t encodeReg(isaPkg::opcode_t op, int rd, int rs1, int rs2);
        return {op, 7'd0, rs2[4:0], 4'd0, rs1[4:0], rd[4:0]};
    endfunction

    // Immediate format with a signed 16-bit field at 25..10
    function automatic isaPkg::word_t encodeImm(isaPkg::opcode_t op, int rd, int rs1,
        logic [15:0] imm);
        return {op, imm, rs1[4:0], rd[4:0]};
    endfunction

    function automatic isaPkg::word_t signExtend(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic checkValue(string testName, isaPkg::word_t expected, isaPkg::word_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", testName, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Value mismatch in %s", testName);
        end
    endtask

    // Program goes in while the core sits in reset
    task automatic loadProgram();
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < progWords.size(); i++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr = isaPkg::word_t'(i);
            progData = progWords[i];
        end
        @(negedge clk);
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        repeat (3) @(negedge clk);
        rst = 1'b1;
    endtask

    task automatic waitHalted();
        while (halted !== 1'b1)
            @(negedge clk);
    endtask

    task automatic testArithmetic();
        logic [15:0] immA;
        logic [15:0] immB;
        isaPkg::word_t sum;
        isaPkg::word_t diff;
        isaPkg::word_t both;
        immA = 16'(nextRandom());
        immB = 16'(nextRandom());
        progWords.delete();
        progWords.push_back(encodeImm(isaPkg::opAddi, 1, 0, immA));
        progWords.push_back(encodeImm(isaPkg::opAddi, 2, 0, immB));
        progWords.push_back(encodeReg(isaPkg::opAdd, 3, 1, 2));
        progWords.push_back(encodeReg(isaPkg::opSub, 4, 1, 3));
        progWords.push_back(encodeReg(isaPkg::opAnd, 5, 4, 3));
        progWords.push_back(encodeReg(isaPkg::opOr, 10, 5, 2));
        progWords.push_back(encodeImm(isaPkg::opHalt, 0, 0, 16'd0));
        loadProgram();
        waitHalted();
        sum = signExtend(immA) + signExtend(immB);
        diff = signExtend(immA) - sum;
        both = diff & sum;
        checkValue("arithmetic", both | signExtend(immB), a0);
    endtask

    task automatic testLoadUse();
        logic [15:0] addr;
        logic [15:0] stored;
        logic [15:0] other;
        addr = {10'd0, 6'(nextRandom())};
        stored = 16'(nextRandom());
        other = 16'(nextRandom());
        progWords.delete();
        progWords.push_back(encodeImm(isaPkg::opAddi, 1, 0, addr));
        progWords.push_back(encodeImm(isaPkg::opAddi, 2, 0, stored));
        progWords.push_back(encodeImm(isaPkg::opAddi, 4, 0, other));
        progWords.push_back(encodeReg(isaPkg::opSw, 0, 1, 2));
        progWords.push_back(encodeReg(isaPkg::opLw, 3, 1, 0));
        // Reads r3 right behind the load
        progWords.push_back(encodeReg(isaPkg::opAdd, 10, 3, 4));
        progWords.push_back(encodeImm(isaPkg::opHalt, 0, 0, 16'd0));
        loadProgram();
        waitHalted();
        checkValue("loadUse", signExtend(stored) + signExtend(other), a0);
    endtask

    task automatic testBranches();
        logic [15:0] base;
        logic [15:0] nonZero;
        base = 16'(nextRandom());
        nonZero = {1'b0, 14'(nextRandom() >> 1), 1'b1};
        progWords.delete();
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 0, base));
        progWords.push_back(encodeImm(isaPkg::opAddi, 5, 0, 16'd0));
        // Taken branch to word 5
        progWords.push_back(encodeImm(isaPkg::opBeqz, 0, 5, 16'd3));
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 10, 16'd100));
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 10, 16'd200));
        progWords.push_back(encodeImm(isaPkg::opAddi, 6, 0, nonZero));
        // Falls through
        progWords.push_back(encodeImm(isaPkg::opBeqz, 0, 6, 16'd3));
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 10, 16'd7));
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 10, 16'd9));
        progWords.push_back(encodeImm(isaPkg::opHalt, 0, 0, 16'd0));
        loadProgram();
        waitHalted();
        checkValue("branches", signExtend(base) + 32'd16, a0);
    endtask

    task automatic testJumpLink();
        isaPkg::word_t jalWord;
        jalWord = 32'd3;
        progWords.delete();
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 0, 16'd55));
        progWords.push_back(encodeImm(isaPkg::opAddi, 2, 0, 16'd1));
        progWords.push_back(encodeImm(isaPkg::opAddi, 3, 0, 16'd2));
        progWords.push_back(encodeImm(isaPkg::opJal, 10, 0, 16'd3));
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 0, 16'd77));
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 10, 16'd99));
        progWords.push_back(encodeImm(isaPkg::opHalt, 0, 0, 16'd0));
        loadProgram();
        waitHalted();
        checkValue("jumpLink", jalWord * 32'd4 + 32'd4, a0);
    endtask

    task automatic testResetRerun();
        logic [15:0] step;
        isaPkg::word_t expected;
        expected = '0;
        progWords.delete();
        progWords.push_back(encodeImm(isaPkg::opAddi, 10, 0, 16'd0));
        for (int i = 0; i < 6; i++) begin
            step = 16'(nextRandom());
            expected = expected + signExtend(step);
            progWords.push_back(encodeImm(isaPkg::opAddi, 10, 10, step));
        end
        progWords.push_back(encodeImm(isaPkg::opHalt, 0, 0, 16'd0));
        loadProgram();
        waitHalted();
        checkValue("resetFirstRun", expected, a0);
        // Second run cut short by reset while the program stays in memory
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        repeat (6) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        checkValue("resetHalted", 32'd0, {31'd0, halted});
        checkValue("resetA0", 32'd0, a0);
        rst = 1'b1;
        waitHalted();
        checkValue("resetRerun", expected, a0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        rngState = 32'h12ccdade;
        testArithmetic();
        testLoadUse();
        testBranches();
        testJumpLink();
        testResetRerun();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* build.f */
logic/isaPkg.sv
logic/pipePkg.sv
logic/decodeBus.sv
logic/fetchUnit.sv
logic/pipelineControl.sv
logic/regFile.sv
logic/executeUnit.sv
logic/memoryUnit.sv
logic/cpuTop.sv
verification/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert -j 0
TOP = cpuTb
FILELIST = build.f
BUILD_DIR = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# A failing run ends in $$fatal, so the binary exits non-zero
sim: build
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
